/* hw/mem_types_pkg.sv */
/*
  Widths and vector types shared by the memory subsystem.
  Data is one 64-bit word per beat, so the byte offset within a word
  is the low three address bits. Only single-beat transfers exist,
  so there are no length or burst fields here.
*/

package mem_types_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Byte address
  parameter int unsigned ADDR_W = 32;

  // Data word
  parameter int unsigned DATA_W = 64;

  // One strobe per data byte
  parameter int unsigned STRB_W = DATA_W / 8;

  // Small transaction tag, echoed on the response
  parameter int unsigned ID_W = 4;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [DATA_W-1:0] data_t;

  typedef logic [STRB_W-1:0] strb_t;

  typedef logic [ID_W-1:0] id_t;

endpackage

/* hw/bus_pkg.sv */
/*
  Bus-level definitions: the response code and the host-exit address.
  Response codes use the AXI encoding so a waveform reads the same
  as on a real interconnect. Only OKAY and SLVERR are ever produced.
*/

package bus_pkg;

  // ----------------------------------------
  // Response codes
  // ----------------------------------------

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // ----------------------------------------
  // Test control
  // ----------------------------------------

  // Store here with bit 0 set ends the test, code in the upper bits
  parameter logic [31:0] TOHOST_ADDR = 32'h0000_1000;

endpackage

/* hw/sram_bank.sv */
/*
  Word-addressed SRAM model with per-byte write enables.
  Read data appears on the edge after the read strobe and holds until
  the next read. Contents start at zero and are not touched by reset.
*/

module sram_bank import mem_types_pkg::*; #(
  parameter int unsigned NUM_WORDS = 1024
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  data_t                        wdata_i,
  input  strb_t                        strb_i,
  output data_t                        rdata_o
);

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  data_t mem_q [NUM_WORDS] = '{default: '0};

  // ----------------------------------------
  // Access port
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled bytes change
        for (int b = 0; b < STRB_W; b++) begin
          if (strb_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

/* hw/bus2mem.sv */
/*
  Bridge from the single-beat request bus to the SRAM strobes.
  Fixed latency of two cycles from acceptance to response valid.
  NUM_WORDS must be a power of two, and the word index plus the byte
  offset must be narrower than the address. Out-of-range addresses
  get SLVERR and never touch the SRAM.
*/

module bus2mem import mem_types_pkg::*, bus_pkg::*; #(
  parameter int unsigned NUM_WORDS = 1024
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Request from the switch
  input  logic                         mem_req_valid_i,
  output logic                         mem_req_ready_o,
  input  logic                         mem_req_write_i,
  input  addr_t                        mem_req_addr_i,
  input  data_t                        mem_req_wdata_i,
  input  strb_t                        mem_req_strb_i,
  input  id_t                          mem_req_id_i,
  // Response to the switch
  output logic                         mem_rsp_valid_o,
  input  logic                         mem_rsp_ready_i,
  output data_t                        mem_rsp_rdata_o,
  output resp_e                        mem_rsp_code_o,
  output id_t                          mem_rsp_id_o,
  // SRAM strobes
  output logic                         sram_req_o,
  output logic                         sram_we_o,
  output logic [$clog2(NUM_WORDS)-1:0] sram_addr_o,
  output data_t                        sram_wdata_o,
  output strb_t                        sram_strb_o,
  input  data_t                        sram_rdata_i
);

  localparam int unsigned IDX_W  = $clog2(NUM_WORDS);
  localparam int unsigned OFFS_W = $clog2(STRB_W);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESP
  } bridge_state_e;

  bridge_state_e state_q;
  bridge_state_e state_d;
  // Second ACCESS cycle, SRAM read data is valid
  logic          phase_q;
  logic          req_fire;

  // Registered request
  logic             write_q;
  logic [IDX_W-1:0] word_q;
  data_t            wdata_q;
  strb_t            strb_q;
  id_t              id_q;
  logic             err_q;
  data_t            rdata_q;

  assign mem_req_ready_o = (state_q == IDLE);
  assign req_fire        = mem_req_valid_i && mem_req_ready_o;

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (mem_req_valid_i) state_d = ACCESS;
      ACCESS:  if (phase_q) state_d = RESP;
      RESP:    if (mem_rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      phase_q <= 1'b0;
    end else begin
      state_q <= state_d;
      phase_q <= (state_q == ACCESS) && !phase_q;
    end
  end

  // ----------------------------------------
  // Request capture and response data
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      write_q <= mem_req_write_i;
      word_q  <= mem_req_addr_i[OFFS_W +: IDX_W];
      wdata_q <= mem_req_wdata_i;
      strb_q  <= mem_req_strb_i;
      id_q    <= mem_req_id_i;
      // Any set bit above the index means past the end
      err_q   <= |mem_req_addr_i[ADDR_W-1:OFFS_W+IDX_W];
    end
    if (state_q == ACCESS && phase_q) begin
      rdata_q <= (write_q || err_q) ? '0 : sram_rdata_i;
    end
  end

  // Strobe only in the first ACCESS cycle
  assign sram_req_o   = (state_q == ACCESS) && !phase_q && !err_q;
  assign sram_we_o    = write_q;
  assign sram_addr_o  = word_q;
  assign sram_wdata_o = wdata_q;
  assign sram_strb_o  = strb_q;

  assign mem_rsp_valid_o = (state_q == RESP);
  assign mem_rsp_rdata_o = rdata_q;
  assign mem_rsp_code_o  = err_q ? RESP_SLVERR : RESP_OKAY;
  assign mem_rsp_id_o    = id_q;

endmodule

/* hw/bus_switch.sv */
/*
  Steers core requests to internal memory or the external port.
  One transaction at a time. The route is taken from ext_active_i at
  request acceptance and held until the response transfers.
  ext_active_i must stay steady while a request waits for ready.
*/

module bus_switch import mem_types_pkg::*, bus_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  ext_active_i,
  // Core side
  input  logic  core_req_valid_i,
  output logic  core_req_ready_o,
  input  logic  core_req_write_i,
  input  addr_t core_req_addr_i,
  input  data_t core_req_wdata_i,
  input  strb_t core_req_strb_i,
  input  id_t   core_req_id_i,
  output logic  core_rsp_valid_o,
  input  logic  core_rsp_ready_i,
  output data_t core_rsp_rdata_o,
  output resp_e core_rsp_code_o,
  output id_t   core_rsp_id_o,
  // Internal memory path
  output logic  mem_req_valid_o,
  input  logic  mem_req_ready_i,
  output logic  mem_req_write_o,
  output addr_t mem_req_addr_o,
  output data_t mem_req_wdata_o,
  output strb_t mem_req_strb_o,
  output id_t   mem_req_id_o,
  input  logic  mem_rsp_valid_i,
  output logic  mem_rsp_ready_o,
  input  data_t mem_rsp_rdata_i,
  input  resp_e mem_rsp_code_i,
  input  id_t   mem_rsp_id_i,
  // External agent path
  output logic  ext_req_valid_o,
  input  logic  ext_req_ready_i,
  output logic  ext_req_write_o,
  output addr_t ext_req_addr_o,
  output data_t ext_req_wdata_o,
  output strb_t ext_req_strb_o,
  output id_t   ext_req_id_o,
  input  logic  ext_rsp_valid_i,
  output logic  ext_rsp_ready_o,
  input  data_t ext_rsp_rdata_i,
  input  resp_e ext_rsp_code_i,
  input  id_t   ext_rsp_id_i
);

  logic busy_q;
  // High when the outstanding transaction went external
  logic route_q;
  logic req_fire;
  logic rsp_fire;

  // ----------------------------------------
  // Request path
  // ----------------------------------------

  // No new request while one is outstanding
  assign core_req_ready_o = !busy_q && (ext_active_i ? ext_req_ready_i : mem_req_ready_i);

  assign mem_req_valid_o = core_req_valid_i && !busy_q && !ext_active_i;
  assign ext_req_valid_o = core_req_valid_i && !busy_q && ext_active_i;

  // Payload fans out to both, only one sees valid
  assign mem_req_write_o = core_req_write_i;
  assign mem_req_addr_o  = core_req_addr_i;
  assign mem_req_wdata_o = core_req_wdata_i;
  assign mem_req_strb_o  = core_req_strb_i;
  assign mem_req_id_o    = core_req_id_i;
  assign ext_req_write_o = core_req_write_i;
  assign ext_req_addr_o  = core_req_addr_i;
  assign ext_req_wdata_o = core_req_wdata_i;
  assign ext_req_strb_o  = core_req_strb_i;
  assign ext_req_id_o    = core_req_id_i;

  // ----------------------------------------
  // Response path
  // ----------------------------------------

  // Selected by the held route, not by the live input
  assign core_rsp_valid_o = busy_q && (route_q ? ext_rsp_valid_i : mem_rsp_valid_i);
  assign core_rsp_rdata_o = route_q ? ext_rsp_rdata_i : mem_rsp_rdata_i;
  assign core_rsp_code_o  = route_q ? ext_rsp_code_i : mem_rsp_code_i;
  assign core_rsp_id_o    = route_q ? ext_rsp_id_i : mem_rsp_id_i;

  assign mem_rsp_ready_o = busy_q && !route_q && core_rsp_ready_i;
  assign ext_rsp_ready_o = busy_q && route_q && core_rsp_ready_i;

  assign req_fire = core_req_valid_i && core_req_ready_o;
  assign rsp_fire = core_rsp_valid_o && core_rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      route_q <= 1'b0;
    end else if (req_fire) begin
      busy_q  <= 1'b1;
      route_q <= ext_active_i;
    end else if (rsp_fire) begin
      busy_q <= 1'b0;
    end
  end

endmodule

/* hw/exit_monitor.sv */
/*
  Watches core stores for the host-exit word.
  A store to TOHOST_ADDR with bit 0 set latches the remaining bits as
  the exit code. The first such store wins, later ones are ignored.
  Byte strobes are not examined, a full-word store is assumed.
*/

module exit_monitor import mem_types_pkg::*, bus_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Core-side request transfer
  input  logic  req_fire_i,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  // Test result
  output logic  exit_valid_o,
  output data_t exit_code_o
);

  logic exit_hit;

  // ----------------------------------------
  // Exit detection
  // ----------------------------------------

  // Bit 0 clear is a plain store to the mailbox
  assign exit_hit = req_fire_i && req_write_i && (req_addr_i == TOHOST_ADDR) && req_wdata_i[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_code_o  <= '0;
    end else if (exit_hit && !exit_valid_o) begin
      exit_valid_o <= 1'b1;
      exit_code_o  <= req_wdata_i >> 1;
    end
  end

endmodule

/* hw/mem_subsys_top.sv */
/*
  Memory side of the processor test harness.
  ext_active_i picks internal SRAM or the external agent per request.
  One transaction in flight at a time, no pipelining.
  NUM_WORDS sets the SRAM depth and must be a power of two, 16 or more.
*/

module mem_subsys_top import mem_types_pkg::*, bus_pkg::*; #(
  parameter int unsigned NUM_WORDS = 1024
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  ext_active_i,
  // Core-side bus
  input  logic  core_req_valid_i,
  output logic  core_req_ready_o,
  input  logic  core_req_write_i,
  input  addr_t core_req_addr_i,
  input  data_t core_req_wdata_i,
  input  strb_t core_req_strb_i,
  input  id_t   core_req_id_i,
  output logic  core_rsp_valid_o,
  input  logic  core_rsp_ready_i,
  output data_t core_rsp_rdata_o,
  output resp_e core_rsp_code_o,
  output id_t   core_rsp_id_o,
  // External agent port
  output logic  ext_req_valid_o,
  input  logic  ext_req_ready_i,
  output logic  ext_req_write_o,
  output addr_t ext_req_addr_o,
  output data_t ext_req_wdata_o,
  output strb_t ext_req_strb_o,
  output id_t   ext_req_id_o,
  input  logic  ext_rsp_valid_i,
  output logic  ext_rsp_ready_o,
  input  data_t ext_rsp_rdata_i,
  input  resp_e ext_rsp_code_i,
  input  id_t   ext_rsp_id_i,
  // End of test
  output logic  exit_valid_o,
  output data_t exit_code_o
);

  localparam int unsigned IDX_W = $clog2(NUM_WORDS);

  // Switch to bridge
  logic  mem_req_valid;
  logic  mem_req_ready;
  logic  mem_req_write;
  addr_t mem_req_addr;
  data_t mem_req_wdata;
  strb_t mem_req_strb;
  id_t   mem_req_id;
  logic  mem_rsp_valid;
  logic  mem_rsp_ready;
  data_t mem_rsp_rdata;
  resp_e mem_rsp_code;
  id_t   mem_rsp_id;

  // Bridge to SRAM
  logic             sram_req;
  logic             sram_we;
  logic [IDX_W-1:0] sram_addr;
  data_t            sram_wdata;
  strb_t            sram_strb;
  data_t            sram_rdata;

  logic core_req_fire;

  assign core_req_fire = core_req_valid_i && core_req_ready_o;

  // ----------------------------------------
  // Route switch
  // ----------------------------------------

  bus_switch u_bus_switch (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ext_active_i     (ext_active_i),
    .core_req_valid_i (core_req_valid_i),
    .core_req_ready_o (core_req_ready_o),
    .core_req_write_i (core_req_write_i),
    .core_req_addr_i  (core_req_addr_i),
    .core_req_wdata_i (core_req_wdata_i),
    .core_req_strb_i  (core_req_strb_i),
    .core_req_id_i    (core_req_id_i),
    .core_rsp_valid_o (core_rsp_valid_o),
    .core_rsp_ready_i (core_rsp_ready_i),
    .core_rsp_rdata_o (core_rsp_rdata_o),
    .core_rsp_code_o  (core_rsp_code_o),
    .core_rsp_id_o    (core_rsp_id_o),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_req_write_o  (mem_req_write),
    .mem_req_addr_o   (mem_req_addr),
    .mem_req_wdata_o  (mem_req_wdata),
    .mem_req_strb_o   (mem_req_strb),
    .mem_req_id_o     (mem_req_id),
    .mem_rsp_valid_i  (mem_rsp_valid),
    .mem_rsp_ready_o  (mem_rsp_ready),
    .mem_rsp_rdata_i  (mem_rsp_rdata),
    .mem_rsp_code_i   (mem_rsp_code),
    .mem_rsp_id_i     (mem_rsp_id),
    .ext_req_valid_o  (ext_req_valid_o),
    .ext_req_ready_i  (ext_req_ready_i),
    .ext_req_write_o  (ext_req_write_o),
    .ext_req_addr_o   (ext_req_addr_o),
    .ext_req_wdata_o  (ext_req_wdata_o),
    .ext_req_strb_o   (ext_req_strb_o),
    .ext_req_id_o     (ext_req_id_o),
    .ext_rsp_valid_i  (ext_rsp_valid_i),
    .ext_rsp_ready_o  (ext_rsp_ready_o),
    .ext_rsp_rdata_i  (ext_rsp_rdata_i),
    .ext_rsp_code_i   (ext_rsp_code_i),
    .ext_rsp_id_i     (ext_rsp_id_i)
  );

  // ----------------------------------------
  // On-chip memory
  // ----------------------------------------

  bus2mem #(
    .NUM_WORDS (NUM_WORDS)
  ) u_bus2mem (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_req_valid_i (mem_req_valid),
    .mem_req_ready_o (mem_req_ready),
    .mem_req_write_i (mem_req_write),
    .mem_req_addr_i  (mem_req_addr),
    .mem_req_wdata_i (mem_req_wdata),
    .mem_req_strb_i  (mem_req_strb),
    .mem_req_id_i    (mem_req_id),
    .mem_rsp_valid_o (mem_rsp_valid),
    .mem_rsp_ready_i (mem_rsp_ready),
    .mem_rsp_rdata_o (mem_rsp_rdata),
    .mem_rsp_code_o  (mem_rsp_code),
    .mem_rsp_id_o    (mem_rsp_id),
    .sram_req_o      (sram_req),
    .sram_we_o       (sram_we),
    .sram_addr_o     (sram_addr),
    .sram_wdata_o    (sram_wdata),
    .sram_strb_o     (sram_strb),
    .sram_rdata_i    (sram_rdata)
  );

  sram_bank #(
    .NUM_WORDS (NUM_WORDS)
  ) u_sram_bank (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .strb_i  (sram_strb),
    .rdata_o (sram_rdata)
  );

  // ----------------------------------------
  // End-of-test detection
  // ----------------------------------------

  exit_monitor u_exit_monitor (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_fire_i   (core_req_fire),
    .req_write_i  (core_req_write_i),
    .req_addr_i   (core_req_addr_i),
    .req_wdata_i  (core_req_wdata_i),
    .exit_valid_o (exit_valid_o),
    .exit_code_o  (exit_code_o)
  );

endmodule

/* verification/tb_clock_gen.sv */
/*
  Clock and reset source for the testbench.
  10 ns clock period. Reset is held low for RESET_CYCLES rising edges
  and released on a falling edge.
*/

module tb_clock_gen #(
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* verification/mem_subsys_checker.sv */
/*
  Handshake assertions on the memory subsystem, bound into the top level.
  Payloads are checked as concatenations of the request fields.
  All properties are disabled while reset is active.
*/

module mem_subsys_checker (
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         core_req_valid_i,
  input logic         core_req_ready_i,
  input logic [108:0] core_payload_i,
  input logic         ext_req_valid_i,
  input logic         ext_req_ready_i,
  input logic [108:0] ext_payload_i,
  input logic         core_rsp_valid_i,
  input logic         core_rsp_ready_i,
  input logic         sram_req_i,
  input logic         mem_req_valid_i,
  input logic         mem_req_ready_i,
  input logic         exit_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Outstanding transaction as seen at the core port
  logic pending_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else if (core_req_valid_i && core_req_ready_i) begin
      pending_q <= 1'b1;
    end else if (core_rsp_valid_i && core_rsp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // Request channels
  // ----------------------------------------

  core_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_req_valid_i && !core_req_ready_i |=> core_req_valid_i && $stable(core_payload_i))
    else $error("core request dropped or changed while waiting for ready");

  ext_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_req_valid_i && !ext_req_ready_i |=> ext_req_valid_i && $stable(ext_payload_i))
    else $error("ext request dropped or changed while waiting for ready");

  // ----------------------------------------
  // One transaction at a time
  // ----------------------------------------

  ready_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pending_q |-> !core_req_ready_i)
    else $error("core_req_ready_o high while a response is pending");

  // Strobe only in the cycle after the bridge accepts a request
  strobe_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sram_req_i |-> $past(mem_req_valid_i && mem_req_ready_i))
    else $error("SRAM strobe outside the first bridge ACCESS cycle");

  exit_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_i |=> exit_valid_i)
    else $error("exit_valid_o fell after rising");

endmodule

bind mem_subsys_top mem_subsys_checker u_checker (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .core_req_valid_i (core_req_valid_i),
  .core_req_ready_i (core_req_ready_o),
  .core_payload_i   ({core_req_write_i, core_req_addr_i, core_req_wdata_i,
                      core_req_strb_i, core_req_id_i}),
  .ext_req_valid_i  (ext_req_valid_o),
  .ext_req_ready_i  (ext_req_ready_i),
  .ext_payload_i    ({ext_req_write_o, ext_req_addr_o, ext_req_wdata_o,
                      ext_req_strb_o, ext_req_id_o}),
  .core_rsp_valid_i (core_rsp_valid_o),
  .core_rsp_ready_i (core_rsp_ready_i),
  .sram_req_i       (sram_req),
  .mem_req_valid_i  (mem_req_valid),
  .mem_req_ready_i  (mem_req_ready),
  .exit_valid_i     (exit_valid_o)
);

/* verification/mem_subsys_tb.sv */
/*
  Testbench for the memory subsystem. Plays the core and the external agent.
  Expected values come from a byte-level model built with the table.
  The agent answers loads with the inverted address and stores with zero.
*/

module mem_subsys_tb import mem_types_pkg::*, bus_pkg::*;;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_WORDS    = 1024;
  localparam int unsigned RESET_CYCLES = 10;

  typedef struct {
    logic  ext;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    id_t   id;
    data_t exp_rdata;
    resp_e exp_code;
    logic  exp_exit;
    data_t exp_exit_code;
  } row_t;

  logic clk;
  logic rst_n;
  logic ext_active_i;
  logic core_req_valid_i;
  logic core_req_ready_o;
  logic core_req_write_i;
  addr_t core_req_addr_i;
  data_t core_req_wdata_i;
  strb_t core_req_strb_i;
  id_t core_req_id_i;
  logic core_rsp_valid_o;
  logic core_rsp_ready_i;
  data_t core_rsp_rdata_o;
  resp_e core_rsp_code_o;
  id_t core_rsp_id_o;
  logic ext_req_valid_o;
  logic ext_req_ready_i;
  logic ext_req_write_o;
  addr_t ext_req_addr_o;
  data_t ext_req_wdata_o;
  strb_t ext_req_strb_o;
  id_t ext_req_id_o;
  logic ext_rsp_valid_i;
  logic ext_rsp_ready_o;
  data_t ext_rsp_rdata_i;
  resp_e ext_rsp_code_i;
  id_t ext_rsp_id_i;
  logic exit_valid_o;
  data_t exit_code_o;

  row_t rows[$];
  logic [7:0] ref_bytes [addr_t];
  logic model_exit;
  data_t model_exit_code;
  int errors;
  int checks;
  int rsp_fires;
  int cycles;
  int cycle_limit;

  // Last request seen by the external agent
  int ext_reqs;
  addr_t ext_addr_seen;
  data_t ext_wdata_seen;
  strb_t ext_strb_seen;

  tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  mem_subsys_top #(.NUM_WORDS(NUM_WORDS)) dut0 (.clk_i(clk), .rst_n_i(rst_n), .*);

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_code(input string name, input resp_e exp, input resp_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // Stimulus table with its reference model
  // ----------------------------------------

  task automatic add_row(input logic ext, input logic write, input addr_t addr,
                         input data_t wdata, input strb_t strb, input id_t id);
    row_t r;
    addr_t ba;
    r = '{ext, write, addr, wdata, strb, id, '0, RESP_OKAY, 1'b0, '0};
    if (write && addr == TOHOST_ADDR && wdata[0] && !model_exit) begin
      model_exit      = 1'b1;
      model_exit_code = wdata >> 1;
    end
    if (ext) begin
      r.exp_rdata = write ? '0 : data_t'(~addr);
    end else if ((addr >> 3) >= NUM_WORDS) begin
      r.exp_code = RESP_SLVERR;
    end else begin
      for (int b = 0; b < STRB_W; b++) begin
        ba = {addr[ADDR_W-1:3], 3'b000} + addr_t'(b);
        if (write && strb[b]) begin
          ref_bytes[ba] = wdata[b*8 +: 8];
        end else if (!write && ref_bytes.exists(ba)) begin
          r.exp_rdata[b*8 +: 8] = ref_bytes[ba];
        end
      end
    end
    r.exp_exit      = model_exit;
    r.exp_exit_code = model_exit_code;
    rows.push_back(r);
  endtask

  task automatic build_table();
    model_exit      = 1'b0;
    model_exit_code = '0;
    // Full words, then read back
    add_row(0, 1, 32'h0000_0000, 64'h0123_4567_89ab_cdef, 8'hff, 4'h1);
    add_row(0, 1, 32'h0000_0008, 64'hfedc_ba98_7654_3210, 8'hff, 4'h2);
    add_row(0, 0, 32'h0000_0000, '0, 8'hff, 4'h3);
    add_row(0, 0, 32'h0000_0008, '0, 8'hff, 4'h4);
    // Partial strobes
    add_row(0, 1, 32'h0000_0010, 64'h1111_2222_3333_4444, 8'hff, 4'h5);
    add_row(0, 1, 32'h0000_0010, 64'haaaa_aaaa_aaaa_aaaa, 8'h0f, 4'h6);
    add_row(0, 1, 32'h0000_0010, 64'h5555_5555_5555_5555, 8'ha0, 4'h7);
    add_row(0, 0, 32'h0000_0010, '0, 8'hff, 4'h8);
    // Past the end of the SRAM
    add_row(0, 1, 32'h0000_2000, 64'hdead_beef_dead_beef, 8'hff, 4'h9);
    add_row(0, 0, 32'h0000_2000, '0, 8'hff, 4'ha);
    add_row(0, 0, 32'h8000_0008, '0, 8'hff, 4'hb);
    add_row(0, 0, 32'h0000_0008, '0, 8'hff, 4'hc);
    // External agent
    add_row(1, 1, 32'h4000_0000, 64'h0bad_f00d_0bad_f00d, 8'hff, 4'hd);
    add_row(1, 0, 32'h4000_0010, '0, 8'hff, 4'he);
    add_row(1, 0, 32'h0000_0000, '0, 8'hff, 4'hf);
    add_row(0, 0, 32'h0000_0000, '0, 8'hff, 4'h0);
    // Host exit
    add_row(0, 1, TOHOST_ADDR, 64'h0000_0000_0000_0006, 8'hff, 4'h1);
    add_row(0, 1, TOHOST_ADDR, 64'h0000_0000_0000_0007, 8'hff, 4'h2);
    add_row(0, 1, TOHOST_ADDR, 64'h0000_0000_0000_0009, 8'hff, 4'h3);
    add_row(0, 0, TOHOST_ADDR, '0, 8'hff, 4'h4);
  endtask

  // ----------------------------------------
  // Core model
  // ----------------------------------------

  task automatic run_row(input int idx);
    row_t r;
    int stall;
    int fires_before;
    int errors_before;
    int ext_before;
    data_t rd;
    resp_e code;
    id_t id;
    r = rows[idx];
    fires_before  = rsp_fires;
    errors_before = errors;
    ext_before    = ext_reqs;
    @(negedge clk);
    ext_active_i     = r.ext;
    core_req_valid_i = 1'b1;
    core_req_write_i = r.write;
    core_req_addr_i  = r.addr;
    core_req_wdata_i = r.wdata;
    core_req_strb_i  = r.strb;
    core_req_id_i    = r.id;
    do @(posedge clk); while (!core_req_ready_o);
    @(negedge clk);
    core_req_valid_i = 1'b0;
    // Flip the route input while the transaction is outstanding
    ext_active_i = !r.ext;
    do @(posedge clk); while (!core_rsp_valid_o);
    stall = $urandom_range(3, 0);
    repeat (stall + 1) @(negedge clk);
    core_rsp_ready_i = 1'b1;
    @(posedge clk);
    if (!core_rsp_valid_o) begin
      errors++;
      $display("Row %0d response valid dropped during a stall", idx);
    end
    rd   = core_rsp_rdata_o;
    code = core_rsp_code_o;
    id   = core_rsp_id_o;
    @(negedge clk);
    core_rsp_ready_i = 1'b0;
    check_data("core_rsp_rdata_o", r.exp_rdata, rd);
    check_code("core_rsp_code_o", r.exp_code, code);
    check_id("core_rsp_id_o", r.id, id);
    check_flag("exit_valid_o", r.exp_exit, exit_valid_o);
    check_data("exit_code_o", r.exp_exit_code, exit_code_o);
    if (rsp_fires != fires_before + 1) begin
      errors++;
      $display("Row %0d saw %0d responses instead of one", idx, rsp_fires - fires_before);
    end
    if (ext_reqs != ext_before + int'(r.ext)) begin
      errors++;
      $display("Row %0d put %0d requests on the external port instead of %0d",
               idx, ext_reqs - ext_before, r.ext);
    end
    if (r.ext) begin
      check_addr("ext_req_addr_o", r.addr, ext_addr_seen);
      check_data("ext_req_wdata_o", r.wdata, ext_wdata_seen);
      check_strb("ext_req_strb_o", r.strb, ext_strb_seen);
    end
    $display("Row %0d %s %s addr %h: %s", idx, r.ext ? "ext" : "mem",
             r.write ? "store" : "load ", r.addr, errors == errors_before ? "ok" : "errors");
  endtask

  always @(posedge clk) begin
    if (rst_n && core_rsp_valid_o && core_rsp_ready_i) begin
      rsp_fires++;
    end
  end

  // ----------------------------------------
  // External agent model
  // ----------------------------------------

  task automatic serve_ext_port();
    logic w;
    id_t i;
    int lat;
    forever begin
      do @(posedge clk); while (!ext_req_valid_o);
      @(negedge clk);
      ext_req_ready_i = 1'b1;
      @(posedge clk);
      w              = ext_req_write_o;
      i              = ext_req_id_o;
      ext_addr_seen  = ext_req_addr_o;
      ext_wdata_seen = ext_req_wdata_o;
      ext_strb_seen  = ext_req_strb_o;
      ext_reqs++;
      @(negedge clk);
      ext_req_ready_i = 1'b0;
      lat = $urandom_range(3, 0);
      repeat (lat) @(negedge clk);
      ext_rsp_valid_i = 1'b1;
      ext_rsp_rdata_i = w ? '0 : data_t'(~ext_addr_seen);
      ext_rsp_code_i  = RESP_OKAY;
      ext_rsp_id_i    = i;
      do @(posedge clk); while (!ext_rsp_ready_o);
      @(negedge clk);
      ext_rsp_valid_i = 1'b0;
    end
  endtask

  // ----------------------------------------
  // Watchdog and main sequence
  // ----------------------------------------

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h1156d263));
    errors           = 0;
    checks           = 0;
    rsp_fires        = 0;
    ext_reqs         = 0;
    cycles           = 0;
    cycle_limit      = 0;
    ext_active_i     = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_write_i = 1'b0;
    core_req_addr_i  = '0;
    core_req_wdata_i = '0;
    core_req_strb_i  = '0;
    core_req_id_i    = '0;
    core_rsp_ready_i = 1'b0;
    ext_req_ready_i  = 1'b0;
    ext_rsp_valid_i  = 1'b0;
    ext_rsp_rdata_i  = '0;
    ext_rsp_code_i   = RESP_OKAY;
    ext_rsp_id_i     = '0;
    fork
      serve_ext_port();
    join_none
    build_table();
    cycle_limit = rows.size() * 12 + RESET_CYCLES;
    @(posedge rst_n);
    for (int k = 0; k < rows.size(); k++) begin
      run_row(k);
    end
    repeat (3) @(negedge clk);
    if (rsp_fires != rows.size()) begin
      errors++;
      $display("Saw %0d responses for %0d requests", rsp_fires, rows.size());
    end
    $display("Summary: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* mem_subsys_top.f */
hw/mem_types_pkg.sv
hw/bus_pkg.sv
hw/sram_bank.sv
hw/bus2mem.sv
hw/bus_switch.sv
hw/exit_monitor.sv
hw/mem_subsys_top.sv
verification/tb_clock_gen.sv
verification/mem_subsys_checker.sv
verification/mem_subsys_tb.sv

/* Makefile */
# Verilator flow for the memory subsystem testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f mem_subsys_top.f --top-module mem_subsys_tb
	verilator --lint-only -Wall -f mem_subsys_top.f --top-module mem_subsys_top \
		hw/mem_subsys_top.sv

sim:
	verilator --binary --timing --assert -j 0 -f mem_subsys_top.f \
		--top-module mem_subsys_tb -o Vmem_subsys_tb
	./obj_dir/Vmem_subsys_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure found in $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
